/* hdl/io_map_pkg.sv */
package io_map_pkg;

	localparam int io_addr_w = 16;
	localparam int io_data_w = 32;
	localparam int io_byte_w = 8;
	localparam int io_size_w = 3;

	typedef logic [io_addr_w-1:0] io_addr_t;
	typedef logic [io_data_w-1:0] io_data_t;
	typedef logic [io_byte_w-1:0] io_byte_t;
	typedef logic [io_size_w-1:0] io_size_t; // access size in bytes.

	// decoded target of a port access.
	typedef enum logic [3:0] {
		dev_none, dev_ide0, dev_ide1, dev_floppy,
		dev_dma, dev_pic, dev_pit, dev_ps2,
		dev_rtc, dev_sound, dev_uart1, dev_uart2,
		dev_mpu, dev_vga, dev_joystick, dev_sysctl
	} io_device_t;

	// each window is a base plus the number of low address bits ignored.
	localparam io_addr_t    ide0_base       = 16'h01F0;
	localparam io_addr_t    ide1_base       = 16'h0170;
	localparam int unsigned ide_bits        = 3;
	localparam io_addr_t    ide0_ctl_port   = 16'h03F6;
	localparam io_addr_t    ide1_ctl_port   = 16'h0376;
	localparam io_addr_t    floppy_base_a   = 16'h03F0;
	localparam int unsigned floppy_bits_a   = 2;
	localparam io_addr_t    floppy_base_b   = 16'h03F4;
	localparam int unsigned floppy_bits_b   = 1;
	localparam io_addr_t    floppy_port_c   = 16'h03F7;
	localparam io_addr_t    dma_master_base = 16'h00C0;
	localparam int unsigned dma_master_bits = 5;
	localparam io_addr_t    dma_page_base   = 16'h0080;
	localparam io_addr_t    dma_slave_base  = 16'h0000;
	localparam int unsigned dma_bits        = 4; // page and slave.
	localparam io_addr_t    pic_master_base = 16'h0020;
	localparam io_addr_t    pic_slave_base  = 16'h00A0;
	localparam int unsigned pic_bits        = 1;
	localparam io_addr_t    pit_base        = 16'h0040;
	localparam int unsigned pit_bits        = 2;
	localparam io_addr_t    pit_port_b      = 16'h0061; // speaker gate.
	localparam io_addr_t    ps2_io_base     = 16'h0060;
	localparam int unsigned ps2_io_bits     = 3;
	localparam io_addr_t    ps2_ctl_base    = 16'h0090;
	localparam int unsigned ps2_ctl_bits    = 4;
	localparam io_addr_t    rtc_base        = 16'h0070;
	localparam int unsigned rtc_bits        = 1;
	localparam io_addr_t    sb_base         = 16'h0220;
	localparam int unsigned sb_bits         = 4;
	localparam io_addr_t    fm_base         = 16'h0388;
	localparam int unsigned fm_bits         = 2;
	localparam io_addr_t    uart1_base      = 16'h03F8;
	localparam io_addr_t    uart2_base      = 16'h02F8;
	localparam int unsigned uart_bits       = 3;
	localparam io_addr_t    mpu_base        = 16'h0330;
	localparam int unsigned mpu_bits        = 1;
	localparam io_addr_t    vga_b_base      = 16'h03B0;
	localparam io_addr_t    vga_c_base      = 16'h03C0;
	localparam io_addr_t    vga_d_base      = 16'h03D0;
	localparam int unsigned vga_bits        = 4;
	localparam io_addr_t    joystick_port   = 16'h0201;
	localparam io_addr_t    sysctl_port_addr = 16'h8888;

	localparam io_byte_t    io_unmapped_data = 8'hFF; // floating bus.

endpackage

/* hdl/sysctl_pkg.sv */
package sysctl_pkg;

	// value of the control port out of reset, before the first disk access.
	localparam logic [7:0] sysctl_boot_value = 8'hA2;

	// a rewrite must carry this byte in write data bits 15..8.
	localparam logic [7:0] sysctl_key = 8'hA1;

	// and must be a 16-bit access.
	localparam logic [2:0] sysctl_size = 3'd2;

endpackage

/* hdl/io_port_decoder.sv */
module io_port_decoder import io_map_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       io_read,
	input  logic       io_write,
	input  io_addr_t   io_address,
	input  io_data_t   io_writedata,
	input  io_size_t   io_datasize,

	output logic       dev_read,
	output logic       dev_write,
	output io_device_t dev_sel,
	output io_addr_t   dev_address,
	output io_data_t   dev_writedata,
	output io_size_t   dev_datasize
);

	io_device_t dev_next;
	logic       access;

	// true when addr falls in the window of base with the low bits ignored.
	function automatic logic port_match(input io_addr_t addr, input io_addr_t base,
		input int unsigned bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	assign access = io_read | io_write;

	// pit is tested ahead of ps2, whose window also covers 0x61.
	always_comb begin
		dev_next = dev_none;
		if (port_match(io_address, ide0_base, ide_bits) || io_address == ide0_ctl_port)
			dev_next = dev_ide0;
		else if (port_match(io_address, ide1_base, ide_bits) || io_address == ide1_ctl_port)
			dev_next = dev_ide1;
		else if (port_match(io_address, floppy_base_a, floppy_bits_a) ||
			port_match(io_address, floppy_base_b, floppy_bits_b) ||
			io_address == floppy_port_c)
			dev_next = dev_floppy;
		else if (port_match(io_address, dma_master_base, dma_master_bits) ||
			port_match(io_address, dma_page_base, dma_bits) ||
			port_match(io_address, dma_slave_base, dma_bits))
			dev_next = dev_dma;
		else if (port_match(io_address, pic_master_base, pic_bits) ||
			port_match(io_address, pic_slave_base, pic_bits))
			dev_next = dev_pic;
		else if (port_match(io_address, pit_base, pit_bits) || io_address == pit_port_b)
			dev_next = dev_pit;
		else if (port_match(io_address, ps2_io_base, ps2_io_bits) ||
			port_match(io_address, ps2_ctl_base, ps2_ctl_bits))
			dev_next = dev_ps2;
		else if (port_match(io_address, rtc_base, rtc_bits))
			dev_next = dev_rtc;
		else if (port_match(io_address, sb_base, sb_bits) ||
			port_match(io_address, fm_base, fm_bits))
			dev_next = dev_sound;
		else if (port_match(io_address, uart1_base, uart_bits))
			dev_next = dev_uart1;
		else if (port_match(io_address, uart2_base, uart_bits))
			dev_next = dev_uart2;
		else if (port_match(io_address, mpu_base, mpu_bits))
			dev_next = dev_mpu;
		else if (port_match(io_address, vga_b_base, vga_bits) ||
			port_match(io_address, vga_c_base, vga_bits) ||
			port_match(io_address, vga_d_base, vga_bits))
			dev_next = dev_vga;
		else if (io_address == joystick_port)
			dev_next = dev_joystick;
		else if (io_address == sysctl_port_addr)
			dev_next = dev_sysctl;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dev_read  <= 1'b0;
			dev_write <= 1'b0;
			dev_sel   <= dev_none;
		end else begin
			dev_read  <= io_read;
			dev_write <= io_write;
			if (access)
				dev_sel <= dev_next; // held between accesses.
		end
	end

	always_ff @(posedge clk_sys) begin
		if (access) begin
			dev_address   <= io_address;
			dev_writedata <= io_writedata;
			dev_datasize  <= io_datasize;
		end
	end

endmodule

/* hdl/sysctl_port.sv */
module sysctl_port
	import io_map_pkg::*;
	import sysctl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       dev_write,
	input  logic       dev_read,
	input  io_device_t dev_sel,
	input  io_data_t   dev_writedata,
	input  io_size_t   dev_datasize,

	output io_byte_t   syscfg
);

	logic in_boot; // set until the first disk access or keyed write.
	logic disk_access;
	logic keyed_write;

	assign disk_access = (dev_read | dev_write) &&
		(dev_sel == dev_ide0 || dev_sel == dev_ide1 || dev_sel == dev_floppy);

	assign keyed_write = dev_write && dev_sel == dev_sysctl &&
		dev_datasize == sysctl_size && dev_writedata[15:8] == sysctl_key;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg  <= sysctl_boot_value;
			in_boot <= 1'b1;
		end else if (disk_access && in_boot) begin
			syscfg  <= '0; // bios has taken over the disks.
			in_boot <= 1'b0;
		end else if (keyed_write) begin
			syscfg  <= dev_writedata[7:0];
			in_boot <= 1'b0;
		end
	end

endmodule

/* hdl/io_read_mux.sv */
module io_read_mux import io_map_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       dev_read,
	input  io_device_t dev_sel,

	input  io_byte_t   rd_floppy,
	input  io_byte_t   rd_dma,
	input  io_byte_t   rd_pic,
	input  io_byte_t   rd_pit,
	input  io_byte_t   rd_ps2,
	input  io_byte_t   rd_rtc,
	input  io_byte_t   rd_sound,
	input  io_byte_t   rd_uart1,
	input  io_byte_t   rd_uart2,
	input  io_byte_t   rd_mpu,
	input  io_byte_t   rd_vga,
	input  io_byte_t   rd_joystick,
	input  io_data_t   rd_ide0,
	input  io_data_t   rd_ide1,

	output io_data_t   read_data,
	output logic       read_valid
);

	io_byte_t byte_data;
	io_data_t wide_data;

	// 8-bit devices; sysctl and unmapped ports read as a floating bus.
	always_comb begin
		case (dev_sel)
			dev_floppy:   byte_data = rd_floppy;
			dev_dma:      byte_data = rd_dma;
			dev_pic:      byte_data = rd_pic;
			dev_pit:      byte_data = rd_pit;
			dev_ps2:      byte_data = rd_ps2;
			dev_rtc:      byte_data = rd_rtc;
			dev_sound:    byte_data = rd_sound;
			dev_uart1:    byte_data = rd_uart1;
			dev_uart2:    byte_data = rd_uart2;
			dev_mpu:      byte_data = rd_mpu;
			dev_vga:      byte_data = rd_vga;
			dev_joystick: byte_data = rd_joystick;
			default:      byte_data = io_unmapped_data;
		endcase
	end

	// ide channels drive the full bus.
	always_comb begin
		if (dev_sel == dev_ide0)
			wide_data = rd_ide0;
		else if (dev_sel == dev_ide1)
			wide_data = rd_ide1;
		else
			wide_data = io_data_t'(byte_data); // zero extend.
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			read_valid <= 1'b0;
		else
			read_valid <= dev_read;
	end

	always_ff @(posedge clk_sys) begin
		if (dev_read)
			read_data <= wide_data;
	end

endmodule

/* hdl/io_fabric.sv */
module io_fabric import io_map_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       io_read,
	input  logic       io_write,
	input  io_addr_t   io_address,
	input  io_data_t   io_writedata,
	input  io_size_t   io_datasize,

	output logic       dev_read,
	output logic       dev_write,
	output io_device_t dev_sel,
	output io_addr_t   dev_address,
	output io_data_t   dev_writedata,
	output io_size_t   dev_datasize,

	input  io_byte_t   rd_floppy,
	input  io_byte_t   rd_dma,
	input  io_byte_t   rd_pic,
	input  io_byte_t   rd_pit,
	input  io_byte_t   rd_ps2,
	input  io_byte_t   rd_rtc,
	input  io_byte_t   rd_sound,
	input  io_byte_t   rd_uart1,
	input  io_byte_t   rd_uart2,
	input  io_byte_t   rd_mpu,
	input  io_byte_t   rd_vga,
	input  io_byte_t   rd_joystick,
	input  io_data_t   rd_ide0,
	input  io_data_t   rd_ide1,

	output io_data_t   read_data,
	output logic       read_valid,
	output io_byte_t   syscfg
);

	// one register stage from the cpu bus to the device strobes.
	io_port_decoder u_decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.io_read       (io_read),
		.io_write      (io_write),
		.io_address    (io_address),
		.io_writedata  (io_writedata),
		.io_datasize   (io_datasize),
		.dev_read      (dev_read),
		.dev_write     (dev_write),
		.dev_sel       (dev_sel),
		.dev_address   (dev_address),
		.dev_writedata (dev_writedata),
		.dev_datasize  (dev_datasize)
	);

	sysctl_port u_sysctl (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dev_write     (dev_write),
		.dev_read      (dev_read),
		.dev_sel       (dev_sel),
		.dev_writedata (dev_writedata),
		.dev_datasize  (dev_datasize),
		.syscfg        (syscfg)
	);

	// devices answer in the dev_read cycle, result is registered here.
	io_read_mux u_read_mux (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dev_read    (dev_read),
		.dev_sel     (dev_sel),
		.rd_floppy   (rd_floppy),
		.rd_dma      (rd_dma),
		.rd_pic      (rd_pic),
		.rd_pit      (rd_pit),
		.rd_ps2      (rd_ps2),
		.rd_rtc      (rd_rtc),
		.rd_sound    (rd_sound),
		.rd_uart1    (rd_uart1),
		.rd_uart2    (rd_uart2),
		.rd_mpu      (rd_mpu),
		.rd_vga      (rd_vga),
		.rd_joystick (rd_joystick),
		.rd_ide0     (rd_ide0),
		.rd_ide1     (rd_ide1),
		.read_data   (read_data),
		.read_valid  (read_valid)
	);

endmodule

/* verification/io_fabric_assert.sv */
module io_fabric_assert (
	input logic clk_sys,
	input logic reset,
	input logic io_write,
	input logic dev_read,
	input logic dev_write,
	input logic read_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // read by the testbench.

	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(dev_read && dev_write))
	else begin
		$error("dev_read and dev_write high in the same cycle");
		fail_count++;
	end

	a_read_valid: assert property (@(posedge clk_sys) disable iff (reset)
		read_valid == $past(dev_read))
	else begin
		$error("read_valid does not follow dev_read by one cycle");
		fail_count++;
	end

	// every bus write reaches the device side.
	a_dev_write: assert property (@(posedge clk_sys) disable iff (reset)
		dev_write == $past(io_write))
	else begin
		$error("dev_write does not follow io_write by one cycle");
		fail_count++;
	end

endmodule

/* verification/io_fabric_tb.sv */
module io_fabric_tb
	import io_map_pkg::*;
	import sysctl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_random    = 400;
	localparam int num_directed  = 12;
	localparam int timeout_limit = 4 * (num_random + num_directed) + 100;

	// window base, ignored low bits and target. first match wins, so 0x61 is the pit.
	localparam io_addr_t map_base [27] = '{
		16'h01F0, 16'h03F6, 16'h0170, 16'h0376, 16'h03F0, 16'h03F4, 16'h03F7,
		16'h00C0, 16'h0080, 16'h0000, 16'h0020, 16'h00A0, 16'h0040, 16'h0061,
		16'h0060, 16'h0090, 16'h0070, 16'h0220, 16'h0388, 16'h03F8, 16'h02F8,
		16'h0330, 16'h03B0, 16'h03C0, 16'h03D0, 16'h0201, 16'h8888};
	localparam int map_bits [27] = '{
		3, 0, 3, 0, 2, 1, 0,
		5, 4, 4, 1, 1, 2, 0,
		3, 4, 1, 4, 2, 3, 3,
		1, 4, 4, 4, 0, 0};
	localparam io_device_t map_dev [27] = '{
		dev_ide0, dev_ide0, dev_ide1, dev_ide1, dev_floppy, dev_floppy, dev_floppy,
		dev_dma, dev_dma, dev_dma, dev_pic, dev_pic, dev_pit, dev_pit,
		dev_ps2, dev_ps2, dev_rtc, dev_sound, dev_sound, dev_uart1, dev_uart2,
		dev_mpu, dev_vga, dev_vga, dev_vga, dev_joystick, dev_sysctl};

	typedef struct packed {
		int         due;
		logic       rd;
		io_device_t sel;
		io_addr_t   addr;
		io_data_t   data;
		io_size_t   size;
	} dev_exp_t;

	typedef struct packed {
		int       due;
		io_data_t value;
	} val_exp_t;

	logic clk_sys;
	logic reset;
	logic io_read;
	logic io_write;
	io_addr_t io_address;
	io_data_t io_writedata;
	io_size_t io_datasize;
	io_byte_t rd_floppy, rd_dma, rd_pic, rd_pit, rd_ps2, rd_rtc;
	io_byte_t rd_sound, rd_uart1, rd_uart2, rd_mpu, rd_vga, rd_joystick;
	io_data_t rd_ide0, rd_ide1;

	logic dev_read;
	logic dev_write;
	io_device_t dev_sel;
	io_addr_t dev_address;
	io_data_t dev_writedata;
	io_size_t dev_datasize;
	io_data_t read_data;
	logic read_valid;
	io_byte_t syscfg;

	dev_exp_t dev_q[$];
	val_exp_t read_q[$];
	val_exp_t cfg_q[$];
	int cycle = 0;
	int run_cycles = 0;
	int unsigned lcg_state = 27;
	io_byte_t model_cfg;
	logic model_boot;
	io_byte_t exp_cfg;

	io_fabric u_dut (.*);

	bind io_fabric io_fabric_assert u_assert (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_write   (io_write),
		.dev_read   (dev_read),
		.dev_write  (dev_write),
		.read_valid (read_valid)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= timeout_limit) begin
			$display("timeout, run still going after %0d cycles", run_cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8; // low bits have a short period.
	endfunction

	function automatic io_device_t model_decode(input io_addr_t addr);
		io_addr_t mask;
		for (int i = 0; i < 27; i++) begin
			mask = io_addr_t'((1 << map_bits[i]) - 1);
			if ((addr & ~mask) == map_base[i])
				return map_dev[i];
		end
		return dev_none;
	endfunction

	function automatic io_data_t model_read(input io_device_t dev);
		case (dev)
			dev_ide0:     return rd_ide0;
			dev_ide1:     return rd_ide1;
			dev_floppy:   return {24'h0, rd_floppy};
			dev_dma:      return {24'h0, rd_dma};
			dev_pic:      return {24'h0, rd_pic};
			dev_pit:      return {24'h0, rd_pit};
			dev_ps2:      return {24'h0, rd_ps2};
			dev_rtc:      return {24'h0, rd_rtc};
			dev_sound:    return {24'h0, rd_sound};
			dev_uart1:    return {24'h0, rd_uart1};
			dev_uart2:    return {24'h0, rd_uart2};
			dev_mpu:      return {24'h0, rd_mpu};
			dev_vga:      return {24'h0, rd_vga};
			dev_joystick: return {24'h0, rd_joystick};
			default:      return 32'h0000_00FF;
		endcase
	endfunction

	function automatic void model_sysctl(input logic wr, input io_device_t dev,
		input io_data_t data, input io_size_t size, input int due);
		val_exp_t v;
		if (model_boot && dev inside {dev_ide0, dev_ide1, dev_floppy}) begin
			model_cfg = 8'h00;
			model_boot = 1'b0;
		end else if (wr && dev == dev_sysctl && size == sysctl_size &&
			data[15:8] == sysctl_key) begin
			model_cfg = data[7:0];
			model_boot = 1'b0;
		end
		v.due = due;
		v.value = {24'h0, model_cfg};
		cfg_q.push_back(v);
	endfunction

	function automatic io_addr_t random_address();
		int unsigned i;
		if (lcg_next() % 2 == 0)
			return io_addr_t'(lcg_next());
		i = lcg_next() % 27;
		return map_base[i] + io_addr_t'(lcg_next() % (1 << map_bits[i]));
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_device(input string name, input io_device_t got, input io_device_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_data(input string name, input io_data_t got, input io_data_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input io_byte_t got, input io_byte_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input io_addr_t got, input io_addr_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_size(input string name, input io_size_t got, input io_size_t exp);
		if (got !== exp)
			report_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// outputs are sampled mid cycle, away from the driving edge.
	task automatic end_cycle();
		dev_exp_t e;
		val_exp_t v;
		@(negedge clk_sys);
		cycle++;
		if (u_dut.u_assert.fail_count != 0)
			report_fail("a bus protocol assertion fired");
		if (dev_q.size() > 0 && dev_q[0].due == cycle) begin
			e = dev_q.pop_front();
			if (dev_read !== e.rd || dev_write !== !e.rd)
				report_fail($sformatf("device strobe missing or wrong in cycle %0d", cycle));
			check_device("dev_sel", dev_sel, e.sel);
			check_addr("dev_address", dev_address, e.addr);
			check_data("dev_writedata", dev_writedata, e.data);
			check_size("dev_datasize", dev_datasize, e.size);
		end else if (dev_read !== 1'b0 || dev_write !== 1'b0)
			report_fail($sformatf("device strobe with no access pending in cycle %0d", cycle));
		if (read_q.size() > 0 && read_q[0].due == cycle) begin
			v = read_q.pop_front();
			if (read_valid !== 1'b1)
				report_fail($sformatf("read_valid missing for a pending read in cycle %0d", cycle));
			check_data("read_data", read_data, v.value);
		end else if (read_valid !== 1'b0)
			report_fail($sformatf("read_valid with no read pending in cycle %0d", cycle));
		if (cfg_q.size() > 0 && cfg_q[0].due == cycle) begin
			v = cfg_q.pop_front();
			exp_cfg = v.value[7:0];
		end
		check_byte("syscfg", syscfg, exp_cfg);
	endtask

	task automatic bus_access(input logic rd, input logic wr, input io_addr_t addr,
		input io_data_t data, input io_size_t size);
		dev_exp_t e;
		val_exp_t v;
		int now;
		@(posedge clk_sys);
		io_read <= rd;
		io_write <= wr;
		io_address <= addr;
		io_writedata <= data;
		io_datasize <= size;
		now = cycle + 1;
		if (rd || wr) begin
			e = '{now + 1, rd, model_decode(addr), addr, data, size};
			dev_q.push_back(e);
			if (rd) begin
				v.due = now + 2;
				v.value = model_read(e.sel);
				read_q.push_back(v);
			end
			model_sysctl(wr, e.sel, data, size, now + 2);
		end
		end_cycle();
	endtask

	task automatic idle(input int n);
		repeat (n) bus_access(1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		io_read <= 1'b0;
		io_write <= 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		dev_q.delete();
		read_q.delete();
		cfg_q.delete();
		model_cfg = sysctl_boot_value;
		model_boot = 1'b1;
		exp_cfg = sysctl_boot_value;
		end_cycle();
	endtask

	// only called with the pipeline drained.
	task automatic randomize_devices();
		@(posedge clk_sys);
		rd_floppy <= io_byte_t'(lcg_next());
		rd_dma <= io_byte_t'(lcg_next());
		rd_pic <= io_byte_t'(lcg_next());
		rd_pit <= io_byte_t'(lcg_next());
		rd_ps2 <= io_byte_t'(lcg_next());
		rd_rtc <= io_byte_t'(lcg_next());
		rd_sound <= io_byte_t'(lcg_next());
		rd_uart1 <= io_byte_t'(lcg_next());
		rd_uart2 <= io_byte_t'(lcg_next());
		rd_mpu <= io_byte_t'(lcg_next());
		rd_vga <= io_byte_t'(lcg_next());
		rd_joystick <= io_byte_t'(lcg_next());
		rd_ide0 <= (lcg_next() << 16) ^ lcg_next();
		rd_ide1 <= (lcg_next() << 16) ^ lcg_next();
		end_cycle();
	endtask

	task automatic random_phase(input int n);
		io_addr_t addr;
		io_data_t data;
		io_size_t size;
		logic rd;
		for (int k = 0; k < n; k++) begin
			addr = random_address();
			data = (lcg_next() << 16) ^ lcg_next();
			size = io_size_t'(1 << (lcg_next() % 3));
			rd = (lcg_next() % 2) == 0;
			if (addr == 16'h8888 && lcg_next() % 2 == 0)
				data[15:8] = sysctl_key; // give keyed writes a fair chance.
			bus_access(rd, !rd, addr, data, size);
			if (lcg_next() % 4 == 0)
				idle(1);
		end
		idle(3);
	endtask

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		io_read = 1'b0;
		io_write = 1'b0;
		io_address = '0;
		io_writedata = '0;
		io_datasize = '0;
		{rd_floppy, rd_dma, rd_pic, rd_pit, rd_ps2, rd_rtc} = '0;
		{rd_sound, rd_uart1, rd_uart2, rd_mpu, rd_vga, rd_joystick} = '0;
		rd_ide0 = '0;
		rd_ide1 = '0;

		apply_reset();
		check_device("dev_sel", dev_sel, dev_none);
		idle(3);

		// first disk access clears the boot value, later ones do not.
		randomize_devices();
		bus_access(1'b1, 1'b0, 16'h03F5, 32'h0, 3'd1);
		bus_access(1'b0, 1'b1, 16'h01F7, 32'h1234_5678, 3'd4);
		bus_access(1'b1, 1'b0, 16'h0376, 32'h0, 3'd1);
		bus_access(0, 1'b1, 16'h8888, 32'h0000_A13C, 3'd2);
		bus_access(1'b0, 1'b1, 16'h8888, 32'h0000_A055, 3'd2); // wrong key.
		bus_access(1'b0, 1'b1, 16'h8888, 32'h0000_A177, 3'd4); // wrong size.
		bus_access(1'b0, 1'b1, 16'h8889, 32'h0000_A177, 3'd2);
		bus_access(1'b1, 1'b0, 16'h8888, 32'h0, 3'd2);
		bus_access(1'b1, 1'b0, 16'h1234, 32'h0, 3'd1);
		bus_access(1'b1, 1'b0, 16'h03F0, 32'h0, 3'd1); // keeps 0x3c.
		idle(3);

		// keyed write ahead of any disk access.
		apply_reset();
		bus_access(1'b0, 1'b1, 16'h8888, 32'h0000_A15A, 3'd2);
		bus_access(1'b1, 1'b0, 16'h01F0, 32'h0, 3'd4);
		idle(3);

		apply_reset();
		randomize_devices();
		random_phase(num_random / 2);
		randomize_devices();
		random_phase(num_random / 2);

		if (u_dut.u_assert.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* list.f */
hdl/io_map_pkg.sv
hdl/sysctl_pkg.sv
hdl/io_port_decoder.sv
hdl/sysctl_port.sv
hdl/io_read_mux.sv
hdl/io_fabric.sv
verification/io_fabric_assert.sv
verification/io_fabric_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module io_fabric_tb -o io_fabric_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/io_fabric_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
